// File: filelist.f
hdl/dm_pkg.sv
hdl/dm_loader.sv
hdl/dm_port_steer.sv
hdl/dm_bank.sv
hdl/dm_line_gather.sv
hdl/dm_top.sv
tb/dm_assertions.sv
tb/dm_tb.sv

// File: Bender.yml
package:
  name: dm_top

sources:
  - hdl/dm_pkg.sv
  - hdl/dm_loader.sv
  - hdl/dm_port_steer.sv
  - hdl/dm_bank.sv
  - hdl/dm_line_gather.sv
  - hdl/dm_top.sv
  - target: simulation
    files:
      - tb/dm_assertions.sv
      - tb/dm_tb.sv

// File: tb/dm_tb.sv
/* directed testbench, the host model answers every READ at once with 16 words
   accelerator traffic starts only after load_done */
`timescale 1ns/10ps

module dm_tb;

    logic               clk;
    logic               rst_n;
    logic               ready;
    logic               rd_valid;
    logic               tx_done;
    logic [31:0]        ex_wrt_data;
    dm_pkg::host_op_t   op;
    logic [63:0]        ex_addr;
    logic [15:0]        accel_addr;
    logic [31:0]        accel_wrt_data;
    logic               accel_wrt_en;
    logic               accel_rd_en;
    logic               accel_wrt_done;
    logic               accel_rd_valid;
    logic [511:0]       accel_rd_data;
    logic               load_done;

    logic [31:0] model [bit [15:0]];   // host words by byte address
    logic [15:0] boot_table [0:16] = '{
        16'h1000, 16'h1040, 16'h1100, 16'h1140, 16'h2000, 16'h2040, 16'h2100, 16'h2140,
        16'h3000, 16'h3040, 16'h3100, 16'h3140, 16'h4000, 16'h4040, 16'h4100, 16'h4140,
        16'h0100
    };
    logic [31:0] rng    = 32'd85;
    int          errors = 0;
    int          checks = 0;
    int          tests  = 0;

    dm_top dut_i (.*);

    initial clk = 1'b0;
    always #20 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////////////////////
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // word i of the line sits at bits 32i upward
    function automatic logic [511:0] expected_line(input logic [15:0] base);
        logic [511:0] line;
        for (int i = 0; i < 16; i++) begin
            line[32*i +: 32] = model[base + 16'(4*i)];
        end
        return line;
    endfunction

    task automatic check_hex(input string name, input logic [511:0] got, input logic [511:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("ERROR %s got %0h expected %0h", name, got, exp);
            errors++;
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout while waiting for %s", what);
        errors++;
    endtask

    task automatic finish_test(input string name, input int err_at_start);
        tests++;
        $display("test %-14s %s (%0d errors)", name,
                 (errors == err_at_start) ? "ok" : "bad", errors - err_at_start);
    endtask

    task automatic read_line(input logic [15:0] addr, output logic [511:0] data);
        int n;
        @(negedge clk);
        accel_addr  = addr;
        accel_rd_en = 1'b1;
        @(negedge clk);
        accel_rd_en = 1'b0;
        n = 0;
        while (!accel_rd_valid && n < 10) begin
            @(negedge clk);
            n++;
        end
        if (!accel_rd_valid) begin
            report_timeout("accel_rd_valid");
        end
        check_hex("read latency", n, 0);   // valid right after the request edge
        data = accel_rd_data;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // tests
    ////////////////////////////////////////////////////////////////////////////
    task automatic test_reset();
        int e0;
        e0 = errors;
        for (int c = 0; c < 10; c++) begin
            @(negedge clk);
            check_hex("op", op, dm_pkg::IDLE);
            check_hex("ex_addr", ex_addr, 0);
            check_hex("load_done", load_done, 0);
            check_hex("accel_wrt_done", accel_wrt_done, 0);
            check_hex("accel_rd_valid", accel_rd_valid, 0);
        end
        finish_test("reset", e0);
    endtask

    task automatic test_boot();
        int          e0;
        int          n;
        logic [15:0] base;
        e0 = errors;
        @(negedge clk);
        ready = 1'b1;
        for (int b = 0; b < 17; b++) begin
            base = boot_table[b];
            @(negedge clk);
            rd_valid = 1'b0;
            tx_done  = 1'b0;
            n = 0;
            while (op !== dm_pkg::READ && n < 20) begin
                @(negedge clk);
                n++;
            end
            if (op !== dm_pkg::READ) begin
                report_timeout("op READ");
            end
            check_hex("ex_addr", ex_addr, {48'h0, base});
            for (int w = 0; w < 16; w++) begin
                if (w > 0) begin
                    @(negedge clk);
                end
                rng = xorshift32(rng);
                model[base + 16'(4*w)] = rng;
                ex_wrt_data = rng;
                rd_valid    = (w == 0);   // strobe marks word 0
                tx_done     = (w == 15);
            end
        end
        @(negedge clk);
        rd_valid = 1'b0;
        tx_done  = 1'b0;
        n = 0;
        while (!load_done && n < 10) begin
            @(negedge clk);
            n++;
        end
        if (!load_done) begin
            report_timeout("load_done");
        end
        check_hex("op", op, dm_pkg::IDLE);
        finish_test("boot", e0);
    endtask

    task automatic test_loaded_lines();
        int           e0;
        logic [511:0] got;
        e0 = errors;
        for (int b = 0; b < 17; b++) begin
            read_line(boot_table[b], got);
            check_hex("accel_rd_data", got, expected_line(boot_table[b]));
        end
        finish_test("loaded_lines", e0);
    endtask

    task automatic test_accel_write();
        int           e0;
        int           n;
        int           blk;
        logic [15:0]  addr;
        logic [511:0] got;
        e0 = errors;
        for (int k = 0; k < 8; k++) begin
            rng  = xorshift32(rng);
            blk  = int'(rng % 17);
            rng  = xorshift32(rng);
            addr = boot_table[blk] + 16'(4 * (rng % 16));
            rng  = xorshift32(rng);
            @(negedge clk);
            accel_addr     = addr;
            accel_wrt_data = rng;
            accel_wrt_en   = 1'b1;
            @(negedge clk);
            accel_wrt_en = 1'b0;
            n = 0;
            while (!accel_wrt_done && n < 10) begin
                @(negedge clk);
                n++;
            end
            if (!accel_wrt_done) begin
                report_timeout("accel_wrt_done");
            end
            check_hex("write latency", n, 0);
            model[addr] = rng;
            read_line(boot_table[blk], got);
            check_hex("accel_rd_data", got, expected_line(boot_table[blk]));
        end
        finish_test("accel_write", e0);
    endtask

    // request k is driven in the same cycle that response k-1 is sampled
    task automatic test_back_to_back();
        int e0;
        int start;
        e0 = errors;
        rng   = xorshift32(rng);
        start = int'(rng % 17);
        for (int k = 0; k <= 6; k++) begin
            @(negedge clk);
            if (k > 0) begin
                check_hex("accel_rd_valid", accel_rd_valid, 1);
                check_hex("accel_rd_data", accel_rd_data,
                          expected_line(boot_table[(start + k - 1) % 17]));
            end
            accel_rd_en = (k < 6);
            accel_addr  = boot_table[(start + k) % 17];
        end
        @(negedge clk);
        check_hex("accel_rd_valid", accel_rd_valid, 0);
        finish_test("back_to_back", e0);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////////////////////
    initial begin
        rst_n          = 1'b0;
        ready          = 1'b0;
        rd_valid       = 1'b0;
        tx_done        = 1'b0;
        ex_wrt_data    = '0;
        accel_addr     = '0;
        accel_wrt_data = '0;
        accel_wrt_en   = 1'b0;
        accel_rd_en    = 1'b0;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        test_reset();
        test_boot();
        test_loaded_lines();
        test_accel_write();
        test_back_to_back();
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: tb/dm_assertions.sv
/* strobe and opcode checks bound into dm_top, all disabled during reset
   write done is only expected once the boot is over */
`timescale 1ns/10ps

module dm_assertions (
    input logic             clk,
    input logic             rst_n,
    input logic             accel_wrt_en,
    input logic             accel_wrt_done,
    input logic             accel_rd_en,
    input logic             accel_rd_valid,
    input dm_pkg::host_op_t op,
    input logic             load_done
);

    // after boot every accelerator write must be taken, done on the next cycle
    wrt_done_follows: assert property (@(posedge clk) disable iff (!rst_n)
        (accel_wrt_en && load_done) |=> accel_wrt_done)
        else $error("accel_wrt_done missing after an accepted write");

    rd_valid_follows: assert property (@(posedge clk) disable iff (!rst_n)
        accel_rd_en |=> accel_rd_valid)
        else $error("accel_rd_valid missing after a read request");

    // host bus is quiet once the boot is over
    op_idle_when_done: assert property (@(posedge clk) disable iff (!rst_n)
        load_done |-> (op == dm_pkg::IDLE))
        else $error("op left IDLE after load_done");

endmodule

bind dm_top dm_assertions assertions_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .accel_wrt_en   (accel_wrt_en),
    .accel_wrt_done (accel_wrt_done),
    .accel_rd_en    (accel_rd_en),
    .accel_rd_valid (accel_rd_valid),
    .op             (op),
    .load_done      (load_done)
);

// File: hdl/dm_top.sv
/* data memory with host boot loader and 512-bit accelerator port
   accelerator traffic is only meaningful once load_done is high */
`timescale 1ns/10ps

module dm_top (
    input  logic                           clk,
    input  logic                           rst_n,
    // host side
    input  logic                           ready,
    input  logic                           rd_valid,
    input  logic                           tx_done,
    input  logic [dm_pkg::word_w-1:0]      ex_wrt_data,
    output dm_pkg::host_op_t               op,
    output logic [dm_pkg::ex_addr_w-1:0]   ex_addr,
    // accelerator side
    input  logic [dm_pkg::addr_w-1:0]      accel_addr,
    input  logic [dm_pkg::word_w-1:0]      accel_wrt_data,
    input  logic                           accel_wrt_en,
    input  logic                           accel_rd_en,
    output logic                           accel_wrt_done,
    output logic                           accel_rd_valid,
    output logic [dm_pkg::line_w-1:0]      accel_rd_data,
    output logic                           load_done
);

    logic                                          ld_wr_en;
    logic [dm_pkg::addr_w-1:0]                     ld_wr_addr;
    logic [dm_pkg::word_w-1:0]                     ld_wr_data;
    logic [dm_pkg::num_banks-1:0]                  bank_wr_en;
    logic [dm_pkg::line_idx_w-1:0]                 wr_line;
    logic [dm_pkg::word_w-1:0]                     wr_data;
    logic [dm_pkg::line_idx_w-1:0]                 rd_line;
    logic                                          rd_pending;
    logic [dm_pkg::num_banks-1:0][dm_pkg::word_w-1:0] bank_q;

    ////////////////////////////////////////////////////////////////////////////
    // boot loader
    ////////////////////////////////////////////////////////////////////////////
    dm_loader loader_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .ready       (ready),
        .rd_valid    (rd_valid),
        .tx_done     (tx_done),
        .ex_wrt_data (ex_wrt_data),
        .op          (op),
        .ex_addr     (ex_addr),
        .ld_wr_en    (ld_wr_en),
        .ld_wr_addr  (ld_wr_addr),
        .ld_wr_data  (ld_wr_data),
        .load_done   (load_done)
    );

    dm_port_steer steer_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .ld_wr_en       (ld_wr_en),
        .ld_wr_addr     (ld_wr_addr),
        .ld_wr_data     (ld_wr_data),
        .accel_addr     (accel_addr),
        .accel_wrt_data (accel_wrt_data),
        .accel_wrt_en   (accel_wrt_en),
        .accel_rd_en    (accel_rd_en),
        .bank_wr_en     (bank_wr_en),
        .wr_line        (wr_line),
        .wr_data        (wr_data),
        .rd_line        (rd_line),
        .rd_pending     (rd_pending),
        .accel_wrt_done (accel_wrt_done)
    );

    ////////////////////////////////////////////////////////////////////////////
    // banks, one per word of the line
    ////////////////////////////////////////////////////////////////////////////
    for (genvar b = 0; b < dm_pkg::num_banks; b++) begin : g_bank
        dm_bank bank_i (
            .clk     (clk),
            .wr_en   (bank_wr_en[b]),
            .wr_line (wr_line),
            .wr_data (wr_data),
            .rd_line (rd_line),
            .q       (bank_q[b])
        );
    end

    dm_line_gather gather_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .rd_pending     (rd_pending),
        .bank_q         (bank_q),
        .accel_rd_data  (accel_rd_data),
        .accel_rd_valid (accel_rd_valid)
    );

endmodule

// File: hdl/dm_line_gather.sv
/* assembles the 16 bank words into one line, valid one cycle after the request
   line data holds until the next read */
`timescale 1ns/10ps

module dm_line_gather (
    input  logic                                          clk,
    input  logic                                          rst_n,
    input  logic                                          rd_pending,
    input  logic [dm_pkg::num_banks-1:0][dm_pkg::word_w-1:0] bank_q,
    output logic [dm_pkg::line_w-1:0]                     accel_rd_data,
    output logic                                          accel_rd_valid
);

    // bank i lands at bits 32i upward
    always_ff @(posedge clk) begin
        if (rd_pending) begin
            for (int i = 0; i < dm_pkg::num_banks; i++) begin
                accel_rd_data[i*dm_pkg::word_w +: dm_pkg::word_w] <= bank_q[i];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            accel_rd_valid <= 1'b0;
        end else begin
            accel_rd_valid <= rd_pending;  // single cycle per request
        end
    end

endmodule

// File: hdl/dm_bank.sv
/* one word column of the data memory, 1024 deep
   read is combinational, a write shows up after its clock edge */
`timescale 1ns/10ps

module dm_bank (
    input  logic                            clk,
    input  logic                            wr_en,
    input  logic [dm_pkg::line_idx_w-1:0]   wr_line,
    input  logic [dm_pkg::word_w-1:0]       wr_data,
    input  logic [dm_pkg::line_idx_w-1:0]   rd_line,
    output logic [dm_pkg::word_w-1:0]       q
);

    logic [dm_pkg::word_w-1:0] mem [0:dm_pkg::num_lines-1];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_line] <= wr_data;
        end
    end

    assign q = mem[rd_line];   // async read

endmodule

// File: hdl/dm_port_steer.sv
/* write arbitration and bank decode, loader wins over the accelerator
   an accelerator write lost to the loader is dropped and gets no done */
`timescale 1ns/10ps

module dm_port_steer (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            ld_wr_en,
    input  logic [dm_pkg::addr_w-1:0]       ld_wr_addr,
    input  logic [dm_pkg::word_w-1:0]       ld_wr_data,
    input  logic [dm_pkg::addr_w-1:0]       accel_addr,
    input  logic [dm_pkg::word_w-1:0]       accel_wrt_data,
    input  logic                            accel_wrt_en,
    input  logic                            accel_rd_en,
    output logic [dm_pkg::num_banks-1:0]    bank_wr_en,
    output logic [dm_pkg::line_idx_w-1:0]   wr_line,
    output logic [dm_pkg::word_w-1:0]       wr_data,
    output logic [dm_pkg::line_idx_w-1:0]   rd_line,
    output logic                            rd_pending,
    output logic                            accel_wrt_done
);

    logic [dm_pkg::addr_w-1:0]       wr_addr;
    logic [dm_pkg::bank_sel_w-1:0]   wr_bank;
    logic                            wr_any;
    logic                            accel_accept;

    ////////////////////////////////////////////////////////////////////////////
    // write path
    ////////////////////////////////////////////////////////////////////////////
    assign accel_accept = accel_wrt_en & ~ld_wr_en;
    assign wr_any       = ld_wr_en | accel_wrt_en;

    assign wr_addr = ld_wr_en ? ld_wr_addr : accel_addr;
    assign wr_data = ld_wr_en ? ld_wr_data : accel_wrt_data;

    assign wr_bank = wr_addr[dm_pkg::bank_sel_w+1:2];                   // word within line
    assign wr_line = wr_addr[dm_pkg::addr_w-1 -: dm_pkg::line_idx_w];   // line index

    // one hot bank enable
    always_comb begin
        bank_wr_en          = '0;
        bank_wr_en[wr_bank] = wr_any;
    end

    // done follows the edge that did the write
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            accel_wrt_done <= 1'b0;
        end else begin
            accel_wrt_done <= accel_accept;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // read path
    ////////////////////////////////////////////////////////////////////////////
    assign rd_line    = accel_addr[dm_pkg::addr_w-1 -: dm_pkg::line_idx_w];
    assign rd_pending = accel_rd_en;   // gather captures on this

endmodule

// File: hdl/dm_loader.sv
/* boot loader, pulls the 17 data blocks from the host after ready
   host strobes are trusted as is, a block must be exactly 16 words */
`timescale 1ns/10ps

module dm_loader (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           ready,
    input  logic                           rd_valid,
    input  logic                           tx_done,
    input  logic [dm_pkg::word_w-1:0]      ex_wrt_data,
    output dm_pkg::host_op_t               op,
    output logic [dm_pkg::ex_addr_w-1:0]   ex_addr,
    output logic                           ld_wr_en,
    output logic [dm_pkg::addr_w-1:0]      ld_wr_addr,
    output logic [dm_pkg::word_w-1:0]      ld_wr_data,
    output logic                           load_done
);

    dm_pkg::load_state_t              state;
    dm_pkg::load_state_t              next_state;
    logic [dm_pkg::block_cnt_w-1:0]   blk_cnt;
    logic [dm_pkg::addr_w-1:0]        base_addr;    // base of current block
    logic [dm_pkg::addr_w-1:0]        stream_addr;  // next word while streaming
    logic                             last_block;

    assign base_addr  = dm_pkg::block_addrs[blk_cnt];
    assign last_block = (blk_cnt == dm_pkg::block_cnt_w'(dm_pkg::num_blocks - 1));

    ////////////////////////////////////////////////////////////////////////////
    // state and counters
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= dm_pkg::LD_IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            blk_cnt <= '0;
        end else if (state == dm_pkg::LD_STREAM && tx_done && !last_block) begin
            blk_cnt <= blk_cnt + 1'b1;
        end
    end

    // word 0 goes to the base, so streaming starts one word in
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stream_addr <= '0;
        end else if (state == dm_pkg::LD_WAIT) begin
            stream_addr <= base_addr + dm_pkg::word_bytes;
        end else if (state == dm_pkg::LD_STREAM) begin
            stream_addr <= stream_addr + dm_pkg::word_bytes;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // next state
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        next_state = state;
        case (state)
            dm_pkg::LD_IDLE: begin
                if (ready) begin
                    next_state = dm_pkg::LD_WAIT;
                end
            end
            dm_pkg::LD_WAIT: begin
                if (rd_valid) begin
                    next_state = dm_pkg::LD_STREAM;
                end
            end
            dm_pkg::LD_STREAM: begin
                // tx_done comes with word 15
                if (tx_done) begin
                    next_state = last_block ? dm_pkg::LD_DONE : dm_pkg::LD_WAIT;
                end
            end
            default: begin
                next_state = dm_pkg::LD_DONE;  // parked for good
            end
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // host request and memory writes
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        op         = dm_pkg::IDLE;
        ex_addr    = '0;
        ld_wr_en   = 1'b0;
        ld_wr_addr = stream_addr;
        case (state)
            dm_pkg::LD_WAIT: begin
                op         = dm_pkg::READ;
                ex_addr    = {{(dm_pkg::ex_addr_w - dm_pkg::addr_w){1'b0}}, base_addr};
                ld_wr_en   = rd_valid;   // word 0 arrives with rd_valid
                ld_wr_addr = base_addr;
            end
            dm_pkg::LD_STREAM: begin
                op       = dm_pkg::READ;
                ex_addr  = {{(dm_pkg::ex_addr_w - dm_pkg::addr_w){1'b0}}, base_addr};
                ld_wr_en = 1'b1;         // one word every cycle
            end
            default: begin
                op = dm_pkg::IDLE;
            end
        endcase
    end

    assign ld_wr_data = ex_wrt_data;
    assign load_done  = (state == dm_pkg::LD_DONE);

endmodule

// File: hdl/dm_pkg.sv
/* shared sizes, boot table and encodings for the line-organized data memory
   host addresses are 64 bits wide but only the low 16 are ever nonzero */

package dm_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // sizes
    ////////////////////////////////////////////////////////////////////////////
    localparam int word_w     = 32;   // data word
    localparam int addr_w     = 16;   // byte address
    localparam int ex_addr_w  = 64;   // host address, upper bits tied low
    localparam int num_banks  = 16;   // words per line
    localparam int line_w     = num_banks * word_w;
    localparam int line_idx_w = 10;   // addr[15:6]
    localparam int num_lines  = 1 << line_idx_w;
    localparam int bank_sel_w = 4;    // addr[5:2]

    // byte step between consecutive words
    localparam logic [addr_w-1:0] word_bytes = 4;

    ////////////////////////////////////////////////////////////////////////////
    // boot blocks
    ////////////////////////////////////////////////////////////////////////////
    localparam int num_blocks  = 17;
    localparam int block_cnt_w = $clog2(num_blocks);

    // fetched in this order, 16 words each
    localparam logic [addr_w-1:0] block_addrs [0:num_blocks-1] = '{
        16'h1000, 16'h1040, 16'h1100, 16'h1140,
        16'h2000, 16'h2040, 16'h2100, 16'h2140,
        16'h3000, 16'h3040, 16'h3100, 16'h3140,
        16'h4000, 16'h4040, 16'h4100, 16'h4140,
        16'h0100
    };

    ////////////////////////////////////////////////////////////////////////////
    // encodings
    ////////////////////////////////////////////////////////////////////////////
    typedef enum logic [1:0] {
        IDLE  = 2'b00,
        READ  = 2'b01,
        WRITE = 2'b11    // host interface code, not issued here
    } host_op_t;

    typedef enum logic [1:0] {
        LD_IDLE,
        LD_WAIT,
        LD_STREAM,
        LD_DONE
    } load_state_t;

endpackage
